/* hdl/cam_capture_ctrl.sv */
////////////////////////////////////////////////////////////
// Capture starts and stops only at frame end. Continuous mode
// stays on until reset once it has been seen
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module cam_capture_ctrl (
   input  logic                    mipi_pclk,
   input  logic                    rst_n,
   input  cam_types_pkg::pix_beat_t pix_i,
   input  logic                    frame_end_i,
   input  logic                    trigger_i,
   input  logic                    continuous_i,
   output cam_types_pkg::pix_beat_t pix_o
);
   import cam_types_pkg::*;

   logic       trig_r1, trig_r2, trig_r3;
   logic       cont_r1, cont_r2;
   logic       cont_hold;
   logic       trig_rise;
   cap_state_t state;

   // Request synchronisers, third trigger flop for the edge
   always_ff @(posedge mipi_pclk or negedge rst_n) begin
      if (!rst_n) begin
         trig_r1   <= 1'b0;
         trig_r2   <= 1'b0;
         trig_r3   <= 1'b0;
         cont_r1   <= 1'b0;
         cont_r2   <= 1'b0;
         cont_hold <= 1'b0;
      end else begin
         trig_r1   <= trigger_i;
         trig_r2   <= trig_r1;
         trig_r3   <= trig_r2;
         cont_r1   <= continuous_i;
         cont_r2   <= cont_r1;
         cont_hold <= cont_hold || cont_r2;
      end
   end

   assign trig_rise = trig_r2 && !trig_r3;

   always_ff @(posedge mipi_pclk or negedge rst_n) begin
      if (!rst_n) begin
         state <= CAP_IDLE;
      end else begin
         case (state)
            CAP_IDLE: begin
               if (cont_hold && frame_end_i) begin
                  state <= CAP_ACTIVE;
               end else if (trig_rise) begin
                  state <= CAP_ARMED;
               end
            end
            CAP_ARMED: begin
               if (frame_end_i) begin
                  state <= CAP_ACTIVE;
               end
            end
            CAP_ACTIVE: begin
               if (frame_end_i && !cont_hold) begin
                  state <= CAP_IDLE;
               end
            end
            default: state <= CAP_IDLE;
         endcase
      end
   end

   assign pix_o.data  = pix_i.data;
   assign pix_o.valid = pix_i.valid && (state == CAP_ACTIVE);

endmodule

/* hdl/cam_capture_top.sv */
////////////////////////////////////////////////////////////
// DMA_TRANSFER_LENGTH must match the DMA firmware burst size,
// FIFO_DEPTH must be a power of two
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module cam_capture_top #(
   parameter int DMA_TRANSFER_LENGTH = 1920,
   parameter int FIFO_DEPTH          = 2048,
   parameter int PCLK_RATE           = 75000000
) (
   input  logic                     mipi_pclk,
   input  logic                     rst_n,
   input  cam_types_pkg::mipi_beat_t mipi_i,
   input  logic                     trigger_capture_i,
   input  logic                     continuous_capture_i,
   input  logic                     dma_init_done_i,
   input  logic                     dma_wready_i,
   output cam_dma_pkg::dma_wr_t      dma_o,
   output logic [31:0]              frames_per_second_o,
   output logic                     fifo_overflow_o,
   output logic [31:0]              fifo_wcount_o,
   output logic [31:0]              dma_rcount_o,
   output logic [2:0]               dma_status_o
);
   import cam_types_pkg::*;
   import cam_dma_pkg::*;

   pix_beat_t  pix_raw;
   pix_beat_t  pix_gated;
   logic       frame_end;
   dma_word_t  fifo_rdata;
   fifo_stat_t fifo_stat;
   logic       fifo_rd_en;
   logic       burst_active;

   cam_input_stage u_input_stage (
      .mipi_pclk   (mipi_pclk),
      .rst_n       (rst_n),
      .mipi_i      (mipi_i),
      .pix_o       (pix_raw),
      .frame_end_o (frame_end)
   );

   cam_capture_ctrl u_capture_ctrl (
      .mipi_pclk    (mipi_pclk),
      .rst_n        (rst_n),
      .pix_i        (pix_raw),
      .frame_end_i  (frame_end),
      .trigger_i    (trigger_capture_i),
      .continuous_i (continuous_capture_i),
      .pix_o        (pix_gated)
   );

   cam_frame_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_frame_fifo (
      .mipi_pclk (mipi_pclk),
      .rst_n     (rst_n),
      .wr_i      (pix_gated),
      .rd_en_i   (fifo_rd_en),
      .rdata_o   (fifo_rdata),
      .stat_o    (fifo_stat)
   );

   cam_dma_writer #(
      .DMA_TRANSFER_LENGTH (DMA_TRANSFER_LENGTH)
   ) u_dma_writer (
      .mipi_pclk      (mipi_pclk),
      .rst_n          (rst_n),
      .init_done_i    (dma_init_done_i),
      .wready_i       (dma_wready_i),
      .fifo_i         (fifo_stat),
      .rdata_i        (fifo_rdata),
      .rd_en_o        (fifo_rd_en),
      .dma_o          (dma_o),
      .burst_active_o (burst_active)
   );

   cam_status_regs #(
      .PCLK_RATE (PCLK_RATE)
   ) u_status_regs (
      .mipi_pclk           (mipi_pclk),
      .rst_n               (rst_n),
      .wr_valid_i          (pix_gated.valid),
      .frame_end_i         (frame_end),
      .overflow_i          (fifo_stat.overflow),
      .dma_wvalid_i        (dma_o.wvalid),
      .fifo_empty_i        (fifo_stat.empty),
      .burst_active_i      (burst_active),
      .wready_i            (dma_wready_i),
      .frames_per_second_o (frames_per_second_o),
      .fifo_overflow_o     (fifo_overflow_o),
      .fifo_wcount_o       (fifo_wcount_o),
      .dma_rcount_o        (dma_rcount_o),
      .dma_status_o        (dma_status_o)
   );

endmodule

/* hdl/cam_dma_pkg.sv */
////////////////////////////////////////////////////////////
// DMA side types. One DMA word is one packed pixel group
////////////////////////////////////////////////////////////

package cam_dma_pkg;

   localparam int DMA_W = 32;

   typedef logic [DMA_W-1:0] dma_word_t;

   typedef struct packed {
      logic      wvalid;
      logic      wlast;
      dma_word_t wdata;
   } dma_wr_t;

   // Overflow is a single-cycle pulse
   typedef struct packed {
      logic empty;
      logic overflow;
   } fifo_stat_t;

   typedef enum logic {
      DMA_IDLE,
      DMA_BURST
   } dma_state_t;

endpackage

/* hdl/cam_dma_writer.sv */
////////////////////////////////////////////////////////////
// One fixed-length burst per rising edge of init. Edges seen
// during a burst are ignored
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module cam_dma_writer #(
   parameter int DMA_TRANSFER_LENGTH = 1920
) (
   input  logic                    mipi_pclk,
   input  logic                    rst_n,
   input  logic                    init_done_i,
   input  logic                    wready_i,
   input  cam_dma_pkg::fifo_stat_t  fifo_i,
   input  cam_dma_pkg::dma_word_t   rdata_i,
   output logic                    rd_en_o,
   output cam_dma_pkg::dma_wr_t     dma_o,
   output logic                    burst_active_o
);
   import cam_dma_pkg::*;

   localparam int CNT_W = $clog2(DMA_TRANSFER_LENGTH + 1);
   localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(DMA_TRANSFER_LENGTH - 1);

   logic             init_r1, init_r2, init_r3;
   logic             init_rise;
   dma_state_t       state;
   logic [CNT_W-1:0] word_cnt;
   logic             wvalid;
   logic             last_word;

   assign init_rise = init_r2 && !init_r3;

   // Word moves only with data in the FIFO and the port ready
   assign wvalid    = (state == DMA_BURST) && !fifo_i.empty && wready_i;
   assign last_word = wvalid && (word_cnt == LAST_CNT);

   always_ff @(posedge mipi_pclk or negedge rst_n) begin
      if (!rst_n) begin
         init_r1  <= 1'b0;
         init_r2  <= 1'b0;
         init_r3  <= 1'b0;
         state    <= DMA_IDLE;
         word_cnt <= '0;
      end else begin
         init_r1 <= init_done_i;
         init_r2 <= init_r1;
         init_r3 <= init_r2;
         case (state)
            DMA_IDLE: begin
               if (init_rise) begin
                  state <= DMA_BURST;
               end
            end
            DMA_BURST: begin
               if (last_word) begin
                  state    <= DMA_IDLE;
                  word_cnt <= '0;
               end else if (wvalid) begin
                  word_cnt <= word_cnt + 1'b1;
               end
            end
            default: state <= DMA_IDLE;
         endcase
      end
   end

   assign rd_en_o        = wvalid;
   assign dma_o.wvalid   = wvalid;
   assign dma_o.wlast    = last_word;
   assign dma_o.wdata    = rdata_i;
   assign burst_active_o = (state == DMA_BURST);

endmodule

/* hdl/cam_frame_fifo.sv */
////////////////////////////////////////////////////////////
// Show-ahead FIFO, FIFO_DEPTH must be a power of two. Writes
// into a full FIFO are lost and reported by the overflow pulse
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module cam_frame_fifo #(
   parameter int FIFO_DEPTH = 2048
) (
   input  logic                     mipi_pclk,
   input  logic                     rst_n,
   input  cam_types_pkg::pix_beat_t  wr_i,
   input  logic                     rd_en_i,
   output cam_dma_pkg::dma_word_t    rdata_o,
   output cam_dma_pkg::fifo_stat_t   stat_o
);
   import cam_types_pkg::*;
   import cam_dma_pkg::*;

   localparam int AW = $clog2(FIFO_DEPTH);

   dma_word_t   mem [FIFO_DEPTH];
   logic [AW:0] wptr;
   logic [AW:0] rptr;
   logic        full;
   logic        empty;
   logic        wr_ok;
   logic        rd_ok;
   logic        overflow_q;

   // Extra pointer bit tells full from empty
   assign empty = (wptr == rptr);
   assign full  = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);
   assign wr_ok = wr_i.valid && !full;
   assign rd_ok = rd_en_i && !empty;

   always_ff @(posedge mipi_pclk) begin
      if (wr_ok) begin
         mem[wptr[AW-1:0]] <= dma_word_t'(wr_i.data);
      end
   end

   always_ff @(posedge mipi_pclk or negedge rst_n) begin
      if (!rst_n) begin
         wptr       <= '0;
         rptr       <= '0;
         overflow_q <= 1'b0;
      end else begin
         if (wr_ok) begin
            wptr <= wptr + 1'b1;
         end
         if (rd_ok) begin
            rptr <= rptr + 1'b1;
         end
         overflow_q <= wr_i.valid && full;
      end
   end

   // Head word is valid whenever the FIFO is not empty
   assign rdata_o         = mem[rptr[AW-1:0]];
   assign stat_o.empty    = empty;
   assign stat_o.overflow = overflow_q;

endmodule

/* hdl/cam_input_stage.sv */
////////////////////////////////////////////////////////////
// Non-RAW10 beats are dropped. hs is not used for framing,
// frame end comes from the falling edge of vs only
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module cam_input_stage (
   input  logic                     mipi_pclk,
   input  logic                     rst_n,
   input  cam_types_pkg::mipi_beat_t mipi_i,
   output cam_types_pkg::pix_beat_t  pix_o,
   output logic                     frame_end_o
);
   import cam_types_pkg::*;

   logic [PPC*RAW_W-1:0] data_q;
   logic                 valid_q;
   logic                 vs_q;
   logic                 vs_r;

   // Only the 4 x 10 bit pixels in the low part of the bus carry data
   always_ff @(posedge mipi_pclk) begin
      data_q <= mipi_i.data[PPC*RAW_W-1:0];
   end

   always_ff @(posedge mipi_pclk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q     <= 1'b0;
         vs_q        <= 1'b0;
         vs_r        <= 1'b0;
         frame_end_o <= 1'b0;
      end else begin
         valid_q     <= mipi_i.valid && (mipi_i.dtype == DT_RAW10);
         vs_q        <= mipi_i.vs;
         vs_r        <= vs_q;
         frame_end_o <= vs_r && !vs_q;
      end
   end

   // Keep bits 9:2 of every pixel
   always_comb begin
      pix_o.valid = valid_q;
      for (int i = 0; i < PPC; i++) begin
         pix_o.data[i] = data_q[i*RAW_W + (RAW_W-PIX_W) +: PIX_W];
      end
   end

endmodule

/* hdl/cam_status_regs.sv */
////////////////////////////////////////////////////////////
// Frame rate is counted over PCLK_RATE clocks, so PCLK_RATE
// must match the real mipi_pclk rate to read as frames/second
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module cam_status_regs #(
   parameter int PCLK_RATE = 75000000
) (
   input  logic        mipi_pclk,
   input  logic        rst_n,
   input  logic        wr_valid_i,
   input  logic        frame_end_i,
   input  logic        overflow_i,
   input  logic        dma_wvalid_i,
   input  logic        fifo_empty_i,
   input  logic        burst_active_i,
   input  logic        wready_i,
   output logic [31:0] frames_per_second_o,
   output logic        fifo_overflow_o,
   output logic [31:0] fifo_wcount_o,
   output logic [31:0] dma_rcount_o,
   output logic [2:0]  dma_status_o
);

   localparam logic [31:0] TIMER_LAST = 32'(PCLK_RATE - 1);

   logic [31:0] timer_cnt;
   logic [31:0] frame_cnt;
   logic        window_end;

   assign window_end = (timer_cnt == TIMER_LAST);

   ////////////////////////////////////////////////////////////
   // Frame rate window
   ////////////////////////////////////////////////////////////
   always_ff @(posedge mipi_pclk or negedge rst_n) begin
      if (!rst_n) begin
         timer_cnt           <= '0;
         frame_cnt           <= '0;
         frames_per_second_o <= '0;
      end else if (window_end) begin
         timer_cnt           <= '0;
         frame_cnt           <= '0;
         // A frame end on the last clock still belongs to this window
         frames_per_second_o <= frame_cnt + {31'd0, frame_end_i};
      end else begin
         timer_cnt <= timer_cnt + 1'b1;
         if (frame_end_i) begin
            frame_cnt <= frame_cnt + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Debug flags and word counters
   ////////////////////////////////////////////////////////////
   always_ff @(posedge mipi_pclk or negedge rst_n) begin
      if (!rst_n) begin
         fifo_overflow_o <= 1'b0;
         fifo_wcount_o   <= '0;
         dma_rcount_o    <= '0;
      end else begin
         fifo_overflow_o <= fifo_overflow_o || overflow_i;
         // Counts gated beats, dropped ones included
         if (wr_valid_i) begin
            fifo_wcount_o <= fifo_wcount_o + 1'b1;
         end
         if (dma_wvalid_i) begin
            dma_rcount_o <= dma_rcount_o + 1'b1;
         end
      end
   end

   assign dma_status_o = {fifo_empty_i, burst_active_i, wready_i};

endmodule

/* hdl/cam_types_pkg.sv */
////////////////////////////////////////////////////////////
// Pixel side types. Input is RAW10, 4 pixels per clock, and only
// the top 8 bits of each pixel are kept
////////////////////////////////////////////////////////////

package cam_types_pkg;

   localparam int PIX_W       = 8;
   localparam int PPC         = 4;
   localparam int RAW_W       = 10;
   localparam int MIPI_DATA_W = 64;

   // MIPI CSI-2 data type code of RAW10
   localparam logic [5:0] DT_RAW10 = 6'h2B;

   // Raw beat as delivered by the MIPI receiver
   typedef struct packed {
      logic [MIPI_DATA_W-1:0] data;
      logic                   valid;
      logic                   vs;
      logic                   hs;
      logic [5:0]             dtype;
   } mipi_beat_t;

   // Pixel 0 sits in the low byte
   typedef logic [PPC-1:0][PIX_W-1:0] pix_group_t;

   typedef struct packed {
      pix_group_t data;
      logic       valid;
   } pix_beat_t;

   typedef enum logic [1:0] {
      CAP_IDLE,
      CAP_ARMED,
      CAP_ACTIVE
   } cap_state_t;

endpackage

/* tb.f */
+incdir+include
hdl/cam_types_pkg.sv
hdl/cam_dma_pkg.sv
hdl/cam_input_stage.sv
hdl/cam_capture_ctrl.sv
hdl/cam_frame_fifo.sv
hdl/cam_dma_writer.sv
hdl/cam_status_regs.sv
hdl/cam_capture_top.sv
test/tb_cam_capture.sv

/* include/tb_cam_tasks.svh */
////////////////////////////////////////////////////////////
// Included inside tb_cam_capture. A frame is 2 lines of 5 beats,
// beat 2 of each line is non-RAW10, so 8 words per frame
////////////////////////////////////////////////////////////
`ifndef TB_CAM_TASKS_SVH
`define TB_CAM_TASKS_SVH

// Embedded data type, never reaches the FIFO
localparam logic [5:0] DT_EMBED = 6'h12;

integer    seed = 80;
dma_word_t exp_q[$];
int        wcount_exp = 0;
int        falls_per_window[64];
int        err_word = 0;
int        err_flag = 0;
int        err_count = 0;
int        err_other = 0;

task automatic next_cycle();
   @(posedge mipi_pclk);
   #1;
endtask

// Bits 9:2 of each pixel, pixel 0 in the low byte
function automatic dma_word_t pack_msbs(input logic [MIPI_DATA_W-1:0] data);
   dma_word_t w;
   for (int p = 0; p < PPC; p++) begin
      w[p*PIX_W +: PIX_W] = data[p*RAW_W + 2 +: PIX_W];
   end
   return w;
endfunction

task automatic drive_frame(input bit capture);
   logic [MIPI_DATA_W-1:0] data;
   int                     w;
   next_cycle();
   mipi.vs = 1'b1;
   repeat (2) next_cycle();
   for (int line = 0; line < 2; line++) begin
      for (int b = 0; b < 5; b++) begin
         data       = {$random(seed), $random(seed)};
         mipi.data  = data;
         mipi.valid = 1'b1;
         mipi.hs    = 1'b1;
         mipi.dtype = (b == 2) ? DT_EMBED : DT_RAW10;
         if (capture && b != 2) begin
            exp_q.push_back(pack_msbs(data));
            wcount_exp++;
         end
         next_cycle();
      end
      mipi.valid = 1'b0;
      mipi.hs    = 1'b0;
      repeat (2) next_cycle();
   end
   mipi.vs = 1'b0;
   // Counted by the DUT three clocks after this vs fall
   w = (win_cyc + 2) / RATE_WINDOW;
   if (w < 64) begin
      falls_per_window[w]++;
   end
   repeat (6) next_cycle();
endtask

task automatic compare_word(input string name, input dma_word_t got, input dma_word_t exp);
   if (got !== exp) begin
      err_word++;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
   end
endtask

task automatic compare_flag(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      err_flag++;
      $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
   end
endtask

task automatic compare_count(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
   if (got !== exp) begin
      err_count++;
      $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
   end
endtask

`endif

/* test/tb_cam_capture.sv */
////////////////////////////////////////////////////////////
// Small build with 8 word bursts, a 16 word FIFO and a 400 clock window
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_cam_capture;
   import cam_types_pkg::*;
   import cam_dma_pkg::*;

   localparam int BURST_LEN   = 8;
   localparam int FIFO_DEPTH  = 16;
   localparam int RATE_WINDOW = 400;
   // Whole sequence runs about 2000 clocks
   localparam int MAX_CYCLES  = 20000;

   logic        mipi_pclk;
   logic        rst_n;
   mipi_beat_t  mipi;
   logic        trigger;
   logic        continuous;
   logic        init_done;
   logic        wready;
   dma_wr_t     dma;
   logic [31:0] fps;
   logic        overflow;
   logic [31:0] wcount;
   logic [31:0] rcount;
   logic [2:0]  status;
   int          cycle_count = 0;
   int          win_cyc = 0;
   int          words_read = 0;
   int          burst_pos = 0;
   bit          init_seen = 1'b0;

   `include "tb_cam_tasks.svh"

   cam_capture_top #(
      .DMA_TRANSFER_LENGTH (BURST_LEN),
      .FIFO_DEPTH          (FIFO_DEPTH),
      .PCLK_RATE           (RATE_WINDOW)
   ) UUT (
      .mipi_pclk            (mipi_pclk),
      .rst_n                (rst_n),
      .mipi_i               (mipi),
      .trigger_capture_i    (trigger),
      .continuous_capture_i (continuous),
      .dma_init_done_i      (init_done),
      .dma_wready_i         (wready),
      .dma_o                (dma),
      .frames_per_second_o  (fps),
      .fifo_overflow_o      (overflow),
      .fifo_wcount_o        (wcount),
      .dma_rcount_o         (rcount),
      .dma_status_o         (status)
   );

   initial begin
      mipi_pclk = 1'b0;
      forever #4 mipi_pclk = ~mipi_pclk;
   end

   always @(posedge mipi_pclk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Run stopped after %0d clocks, a burst never completed", MAX_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   // Mirrors the frame rate timer and clears with reset
   always @(posedge mipi_pclk) begin
      if (!rst_n) begin
         win_cyc <= 0;
      end else begin
         win_cyc <= win_cyc + 1;
      end
   end

   ////////////////////////////////////////////////////////////
   // DMA port monitor sampled mid-cycle
   ////////////////////////////////////////////////////////////
   always @(negedge mipi_pclk) begin
      if (rst_n && dma.wvalid) begin
         if (!init_seen) begin
            err_other++;
            $display("DMA word written at %0t ns before any init request", $time);
         end
         compare_flag("dma_wready_i at write", wready, 1'b1);
         // Burst active with data in the FIFO and wready high
         compare_count("dma_status_o", {29'd0, status}, 32'd3);
         if (exp_q.size() == 0) begin
            err_other++;
            $display("DMA word at %0t ns has no captured pixels to match", $time);
         end else begin
            compare_word("dma_o.wdata", dma.wdata, exp_q.pop_front());
         end
         compare_flag("dma_o.wlast", dma.wlast, burst_pos == BURST_LEN - 1);
         burst_pos = (burst_pos == BURST_LEN - 1) ? 0 : burst_pos + 1;
         words_read++;
      end else if (rst_n) begin
         compare_flag("dma_o.wlast", dma.wlast, 1'b0);
      end
   end

   // One init pulse, then wait for its burst and make sure it stops
   task automatic run_burst(input bit random_ready);
      int target;
      target = words_read + BURST_LEN;
      init_done = 1'b1;
      init_seen = 1'b1;
      while (words_read < target) begin
         next_cycle();
         init_done = 1'b0;
         wready    = random_ready ? (($random(seed) % 2) != 0) : 1'b1;
      end
      wready = 1'b1;
      repeat (12) next_cycle();
      compare_count("dma_rcount_o", rcount, target);
      // Writer idle with wready high. FIFO empty once the model holds no words
      compare_count("dma_status_o", {29'd0, status}, {29'd0, exp_q.size() == 0, 2'b01});
   endtask

   task automatic capture_one_frame();
      trigger = 1'b1;
      drive_frame(1'b0);
      trigger = 1'b0;
      drive_frame(1'b1);
   endtask

   task automatic check_reset_values();
      compare_flag("dma_o.wvalid", dma.wvalid, 1'b0);
      compare_flag("dma_o.wlast", dma.wlast, 1'b0);
      compare_flag("fifo_overflow_o", overflow, 1'b0);
      compare_count("frames_per_second_o", fps, 32'd0);
      compare_count("fifo_wcount_o", wcount, 32'd0);
      compare_count("dma_rcount_o", rcount, 32'd0);
      // Empty FIFO, no burst, wready low
      compare_count("dma_status_o", {29'd0, status}, 32'd4);
   endtask

   task automatic check_no_request();
      drive_frame(1'b0);
      drive_frame(1'b0);
      compare_count("fifo_wcount_o", wcount, 32'd0);
      compare_flag("fifo empty", status[2], 1'b1);
   endtask

   task automatic check_single_capture();
      capture_one_frame();
      drive_frame(1'b0);
      compare_count("fifo_wcount_o", wcount, wcount_exp);
      run_burst(1'b0);
      compare_count("words left in model", exp_q.size(), 32'd0);
   endtask

   task automatic check_random_ready_bursts();
      capture_one_frame();
      capture_one_frame();
      // FIFO now exactly full
      compare_flag("fifo_overflow_o", overflow, 1'b0);
      run_burst(1'b1);
      run_burst(1'b1);
      compare_count("words left in model", exp_q.size(), 32'd0);
   endtask

   task automatic check_continuous_rate();
      int win;
      continuous = 1'b1;
      drive_frame(1'b0);
      win = win_cyc / RATE_WINDOW + 1;
      while (win_cyc < win * RATE_WINDOW) begin
         next_cycle();
      end
      while (win_cyc < (win + 1) * RATE_WINDOW + 2) begin
         drive_frame(1'b1);
         run_burst(1'b0);
      end
      compare_count("frames_per_second_o", fps, falls_per_window[win]);
      compare_count("fifo_wcount_o", wcount, wcount_exp);
   endtask

   task automatic check_overflow();
      repeat (3) drive_frame(1'b1);
      compare_flag("fifo_overflow_o", overflow, 1'b1);
      compare_count("fifo_wcount_o", wcount, wcount_exp);
      repeat (20) next_cycle();
      compare_flag("fifo_overflow_o", overflow, 1'b1);
      // Dropped words never reach the DMA port
      exp_q.delete();
   endtask

   initial begin
      mipi       = '0;
      trigger    = 1'b0;
      continuous = 1'b0;
      init_done  = 1'b0;
      wready     = 1'b0;
      rst_n      = 1'b0;
      repeat (8) @(posedge mipi_pclk);
      #1;
      rst_n = 1'b1;
      next_cycle();
      check_reset_values();
      check_no_request();
      check_single_capture();
      check_random_ready_bursts();
      check_continuous_rate();
      check_overflow();
      $display("word errors %0d, flag errors %0d, count errors %0d, other errors %0d",
               err_word, err_flag, err_count, err_other);
      if (err_word + err_flag + err_count + err_other == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
